// ==== all.f ====
src/fp_pkg.sv
src/bus_arbiter.sv
src/ahb_matrix.sv
src/tcm_sram.sv
src/ahb_to_apb.sv
src/apb_regs.sv
src/fp_domain.sv
verification/tb_clock.sv
verification/tb_fp_domain.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the full power domain testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_fp_domain -f all.f -o sim_fp_domain || exit 1
./obj_dir/sim_fp_domain | tee /dev/stderr | grep -qx "sim passed" && exit 0 || exit 1

// ==== verification/tb_fp_domain.sv ====
// Full power domain testbench

`timescale 1ns/1ps

module tb_fp_domain;

	import fp_pkg::*;

	localparam int XFER_BUDGET = 600;
	localparam int CYCLE_LIMIT = XFER_BUDGET * 12 + 400;	// 12 cycles per transfer plus margin

	logic sys_root_clk;
	logic rst_n;
	ahb_req_t mst_req [NUM_MASTERS];
	ahb_rsp_t mst_rsp [NUM_MASTERS];
	int check_cnt = 0;
	int err_cnt = 0;
	int cycle_cnt = 0;

	// Reference model
	// Known bits mark the bytes written so far
	logic [DATA_W-1:0] itcm_model [ITCM_WORDS];
	logic [STRB_W-1:0] itcm_known [ITCM_WORDS];
	logic [DATA_W-1:0] dtcm_model [DTCM_WORDS];
	logic [STRB_W-1:0] dtcm_known [DTCM_WORDS];
	logic [DATA_W-1:0] reg_model [NUM_APB_REGS];		// Bank resets to 0

	tb_clock u_tb_clock (.clk(sys_root_clk));

	fp_domain u_dut (
		.sys_root_clk	(sys_root_clk),
		.rst_n			(rst_n),
		.mst_req		(mst_req),
		.mst_rsp		(mst_rsp)
	);

	// ======================================================================
	// Helpers
	// ======================================================================
	task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] got);
		check_cnt++;
		assert (got === exp) else begin
			$display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
			err_cnt++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		check_cnt++;
		assert (cond) else begin
			$display("ERROR t=%0t %s", $time, what);
			err_cnt++;
		end
	endtask

	function automatic logic [DATA_W-1:0] byte_mask(input logic [STRB_W-1:0] strb);
		logic [DATA_W-1:0] mask;

		for (int b = 0; b < STRB_W; b++)
			mask[8*b +: 8] = {8{strb[b]}};
		return mask;
	endfunction

	// Memory map as bounds with APB matched on its upper half-word
	function automatic target_e region_of(input logic [ADDR_W-1:0] addr);
		if (addr >= ITCM_BASE && addr < ITCM_BASE + ADDR_W'(ITCM_WORDS * 4))
			return ITCM;
		else if (addr >= DTCM_BASE && addr < DTCM_BASE + ADDR_W'(DTCM_WORDS * 4))
			return DTCM;
		else if (addr[31:16] == APB_BASE[31:16])
			return APB;
		return NONE;
	endfunction

	function automatic int uncontended_latency(input target_e t);
		case (t)
			ITCM, DTCM: return 3;
			APB:        return 4;		// Setup plus access
			default:    return 2;
		endcase
	endfunction

	function automatic logic [ADDR_W-1:0] pick_addr(input int kind);
		logic [ADDR_W-1:0] addr;

		case (kind)
			0: addr = ITCM_BASE + (ADDR_W'($urandom_range(ITCM_WORDS - 1, 0)) << 2);
			1: addr = DTCM_BASE + (ADDR_W'($urandom_range(DTCM_WORDS - 1, 0)) << 2);
			2: addr = APB_BASE + (ADDR_W'($urandom_range(NUM_APB_REGS - 1, 0)) << 2);
			3: addr = APB_BASE + (ADDR_W'($urandom_range(16383, NUM_APB_REGS)) << 2);	// Past bank
			default: addr = 32'h2000_0000 | ($urandom & 32'h0FFF_FFFC);		// Unmapped
		endcase
		return addr;
	endfunction

	// ======================================================================
	// One transfer checked against the model on ready
	// ======================================================================
	task automatic transfer(input int m, input logic wr, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb, input int exp_lat);
		ahb_rsp_t rsp;
		int cycles;
		int others;
		int word;
		logic exp_err;
		logic [DATA_W-1:0] exp_data;
		logic [DATA_W-1:0] cmp_mask;
		logic [DATA_W-1:0] wmask;

		if (exp_lat > 0) begin
			@(negedge sys_root_clk);	// Idle cycle that also catches a repeated pulse
			check_true(!mst_rsp[m].ready, $sformatf("master %0d saw ready with no request", m));
		end
		mst_req[m] = '{sel: 1'b1, write: wr, addr: addr, wdata: wdata, strb: strb};
		rsp = '0;
		cycles = 0;
		others = 0;
		while (!rsp.ready) begin
			@(negedge sys_root_clk);
			cycles++;
			rsp = mst_rsp[m];
			for (int j = 0; j < NUM_MASTERS; j++)
				if (j != m && mst_rsp[j].ready)
					others++;		// Served while this one waits
		end
		mst_req[m].sel = 1'b0;

		exp_err = 1'b0;
		exp_data = '0;
		cmp_mask = '1;
		wmask = byte_mask(strb);
		case (region_of(addr))
			ITCM: begin
				word = int'((addr - ITCM_BASE) >> 2);
				if (wr) begin
					itcm_model[word] = (itcm_model[word] & ~wmask) | (wdata & wmask);
					itcm_known[word] |= strb;
				end else begin
					exp_data = itcm_model[word];
					cmp_mask = byte_mask(itcm_known[word]);		// Unwritten bytes skipped
				end
			end
			DTCM: begin
				word = int'((addr - DTCM_BASE) >> 2);
				if (wr) begin
					dtcm_model[word] = (dtcm_model[word] & ~wmask) | (wdata & wmask);
					dtcm_known[word] |= strb;
				end else begin
					exp_data = dtcm_model[word];
					cmp_mask = byte_mask(dtcm_known[word]);
				end
			end
			APB: begin
				word = int'((addr - APB_BASE) >> 2);
				if (word >= NUM_APB_REGS)
					exp_err = 1'b1;			// Slave error with rdata 0
				else if (wr)
					reg_model[word] = (reg_model[word] & ~wmask) | (wdata & wmask);
				else
					exp_data = reg_model[word];
			end
			default: exp_err = 1'b1;
		endcase

		check_value($sformatf("mst_rsp[%0d].err", m), 32'(exp_err), 32'(rsp.err));
		if (!wr || exp_err)
			check_value($sformatf("mst_rsp[%0d].rdata", m), exp_data & cmp_mask,
				rsp.rdata & cmp_mask);
		check_true(cycles >= 2, $sformatf("master %0d got ready right after sel", m));
		check_true(others <= 2, $sformatf("master %0d waited through %0d completions", m, others));
		if (exp_lat > 0)
			check_value($sformatf("mst_rsp[%0d].ready latency", m), 32'(exp_lat), 32'(cycles));
	endtask

	task automatic random_xfer(input int m, input int kind, input logic timed);
		logic [ADDR_W-1:0] addr;
		logic wr;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] strb;

		addr = pick_addr(kind);
		wr = 1'($urandom_range(1, 0));
		wdata = $urandom;
		strb = STRB_W'($urandom);
		transfer(m, wr, addr, wdata, strb, timed ? uncontended_latency(region_of(addr)) : 0);
	endtask

	task automatic master_stream(input int m, input int count);
		for (int n = 0; n < count; n++) begin
			int gap;

			gap = int'($urandom_range(2, 0));
			// No ready may show up between two requests
			for (int g = 0; g < gap; g++) begin
				@(negedge sys_root_clk);
				check_true(!mst_rsp[m].ready,
					$sformatf("master %0d saw ready with no request", m));
			end
			random_xfer(m, int'($urandom_range(4, 0)), 1'b0);
		end
	endtask

	task automatic check_idle_rsp();
		for (int m = 0; m < NUM_MASTERS; m++) begin
			check_value($sformatf("mst_rsp[%0d].ready", m), '0, 32'(mst_rsp[m].ready));
			check_value($sformatf("mst_rsp[%0d].err", m), '0, 32'(mst_rsp[m].err));
		end
	endtask

	// ======================================================================
	// Stimulus
	// ======================================================================
	initial begin
		int word;
		logic [ADDR_W-1:0] hole;

		rst_n = 1'b0;
		for (int m = 0; m < NUM_MASTERS; m++)
			mst_req[m] = '0;
		for (int w = 0; w < ITCM_WORDS; w++) begin
			itcm_model[w] = '0;
			itcm_known[w] = '0;
		end
		for (int w = 0; w < DTCM_WORDS; w++) begin
			dtcm_model[w] = '0;
			dtcm_known[w] = '0;
		end
		for (int r = 0; r < NUM_APB_REGS; r++)
			reg_model[r] = '0;
		void'($urandom(32'h32a0_d650));

		repeat (5) begin
			@(negedge sys_root_clk);
			check_idle_rsp();
		end
		rst_n = 1'b1;
		repeat (2) begin
			@(negedge sys_root_clk);
			check_idle_rsp();
		end

		// TCM accesses one master at a time
		for (int i = 0; i < 300; i++)
			random_xfer(int'($urandom_range(NUM_MASTERS - 1, 0)), int'($urandom_range(1, 0)), 1'b1);
		// Register bank with a quarter past its end
		for (int i = 0; i < 100; i++)
			random_xfer(int'($urandom_range(NUM_MASTERS - 1, 0)),
				($urandom_range(3, 0) == 0) ? 3 : 2, 1'b1);

		// Unmapped gap above the ITCM must not alias into it
		for (int i = 0; i < 8; i++) begin
			word = int'($urandom_range(ITCM_WORDS - 1, 0));
			hole = 32'h0000_0400 + (ADDR_W'(word) << 2);
			transfer(0, 1'b1, ITCM_BASE + (ADDR_W'(word) << 2), $urandom, 4'hF, 3);
			transfer(1, 1'b1, hole, $urandom, 4'hF, 2);
			transfer(2, 1'b0, hole, '0, 4'h0, 2);
			transfer(0, 1'b0, ITCM_BASE + (ADDR_W'(word) << 2), '0, 4'h0, 3);
		end

		// All masters at once
		fork
			master_stream(0, 50);
			master_stream(1, 50);
			master_stream(2, 50);
		join

		$display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// Watchdog
	initial begin
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge sys_root_clk);
			cycle_cnt++;
		end
		$display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Checks run: %0d, errors: %0d", check_cnt, err_cnt + 1);
		$display("sim failed");
		$finish;
	end

endmodule

// ==== verification/tb_clock.sv ====
// Testbench clock generator

`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;		// 100 ns period
	end

endmodule

// ==== src/fp_domain.sv ====
// Full power domain top

`timescale 1ns/1ps

module fp_domain (
	input  logic sys_root_clk,
	input  logic rst_n,
	input  fp_pkg::ahb_req_t mst_req [fp_pkg::NUM_MASTERS],	// 0 instr, 1 data, 2 system
	output fp_pkg::ahb_rsp_t mst_rsp [fp_pkg::NUM_MASTERS]
);

	import fp_pkg::*;

	ahb_req_t tcm_req;
	target_e tcm_target;
	ahb_rsp_t tcm_rsp;
	ahb_req_t apb_br_req;
	ahb_rsp_t apb_br_rsp;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;

	// ======================================================================
	// Interconnect
	// ======================================================================
	ahb_matrix u_ahb_matrix (
		.sys_root_clk	(sys_root_clk),
		.rst_n			(rst_n),
		.mst_req		(mst_req),
		.mst_rsp		(mst_rsp),
		.tcm_req		(tcm_req),
		.tcm_target		(tcm_target),
		.tcm_rsp		(tcm_rsp),
		.apb_br_req		(apb_br_req),
		.apb_br_rsp		(apb_br_rsp)
	);

	// ITCM 0x0000_0000, DTCM 0x0001_0000
	tcm_sram u_tcm_sram (
		.sys_root_clk	(sys_root_clk),
		.rst_n			(rst_n),
		.req			(tcm_req),
		.target			(tcm_target),
		.rsp			(tcm_rsp)
	);

	// ======================================================================
	// APB window 0x4000_0000 ~ 0x4000_FFFF
	// ======================================================================
	ahb_to_apb u_ahb_to_apb (
		.sys_root_clk	(sys_root_clk),
		.rst_n			(rst_n),
		.ahb_req		(apb_br_req),
		.ahb_rsp		(apb_br_rsp),
		.apb_req		(apb_req),
		.apb_rsp		(apb_rsp)
	);

	apb_regs u_apb_regs (
		.sys_root_clk	(sys_root_clk),
		.rst_n			(rst_n),
		.apb_req		(apb_req),
		.apb_rsp		(apb_rsp)
	);

endmodule

// ==== src/apb_regs.sv ====
// APB register bank

`timescale 1ns/1ps

module apb_regs (
	input  logic sys_root_clk,
	input  logic rst_n,
	input  fp_pkg::apb_req_t apb_req,
	output fp_pkg::apb_rsp_t apb_rsp
);

	import fp_pkg::*;

	logic [DATA_W-1:0] regs [NUM_APB_REGS];
	logic [APB_REG_AW-1:0] idx;
	logic access;
	logic bad_off;		// Offset past the bank

	assign access = apb_req.psel && apb_req.penable;
	assign idx = apb_req.paddr[APB_REG_AW+1:2];
	assign bad_off = |apb_req.paddr[ADDR_W-1:APB_REG_AW+2];

	always_ff @(posedge sys_root_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < NUM_APB_REGS; r++)
				regs[r] <= '0;
		end else if (access && apb_req.pwrite && !bad_off) begin
			for (int b = 0; b < STRB_W; b++)
				if (apb_req.pstrb[b])
					regs[idx][8*b +: 8] <= apb_req.pwdata[8*b +: 8];	// Enabled lanes
		end
	end

	// Zero wait states
	always_comb begin
		apb_rsp.pready = access;
		apb_rsp.pslverr = access && bad_off;
		apb_rsp.prdata = bad_off ? '0 : regs[idx];
	end

endmodule

// ==== src/ahb_to_apb.sv ====
// Synchronous AHB to APB bridge

`timescale 1ns/1ps

module ahb_to_apb (
	input  logic sys_root_clk,
	input  logic rst_n,
	input  fp_pkg::ahb_req_t ahb_req,
	output fp_pkg::ahb_rsp_t ahb_rsp,
	output fp_pkg::apb_req_t apb_req,
	input  fp_pkg::apb_rsp_t apb_rsp
);

	import fp_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETUP,		// psel only
		ST_ACCESS		// psel and penable until pready
	} br_state_e;

	br_state_e state_q;
	br_state_e state_d;
	logic done;

	// ======================================================================
	// Sequencer
	// ======================================================================
	assign done = (state_q == ST_ACCESS) && apb_rsp.pready;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:   if (ahb_req.sel) state_d = ST_SETUP;
			ST_SETUP:  state_d = ST_ACCESS;
			ST_ACCESS: if (apb_rsp.pready) state_d = ST_IDLE;
			default:   state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge sys_root_clk or negedge rst_n) begin
		if (!rst_n)
			state_q <= ST_IDLE;
		else
			state_q <= state_d;
	end

	// ======================================================================
	// APB side, AHB request stays stable while sel is held
	// ======================================================================
	always_comb begin
		apb_req.psel = (state_q != ST_IDLE);
		apb_req.penable = (state_q == ST_ACCESS);
		apb_req.pwrite = ahb_req.write;
		apb_req.paddr = ahb_req.addr & ~APB_REGION_MASK;	// Window offset
		apb_req.pwdata = ahb_req.wdata;
		apb_req.pstrb = ahb_req.write ? ahb_req.strb : '0;	// No strobes on reads
	end

	// AHB side
	always_comb begin
		ahb_rsp.ready = done;
		ahb_rsp.err = done && apb_rsp.pslverr;
		ahb_rsp.rdata = apb_rsp.prdata;
	end

endmodule

// ==== src/tcm_sram.sv ====
// Instruction and data TCM

`timescale 1ns/1ps

module tcm_sram (
	input  logic sys_root_clk,
	input  logic rst_n,
	input  fp_pkg::ahb_req_t req,
	input  fp_pkg::target_e  target,	// ITCM or DTCM
	output fp_pkg::ahb_rsp_t rsp
);

	import fp_pkg::*;

	logic [DATA_W-1:0] itcm_mem [ITCM_WORDS];
	logic [DATA_W-1:0] dtcm_mem [DTCM_WORDS];
	logic [ADDR_W-1:0] itcm_off;
	logic [ADDR_W-1:0] dtcm_off;
	logic [ITCM_AW-1:0] itcm_idx;
	logic [DTCM_AW-1:0] dtcm_idx;
	logic access;
	logic ready_q;
	logic [DATA_W-1:0] rdata_q;

	// Word offsets from each region base
	assign itcm_off = req.addr - ITCM_BASE;
	assign dtcm_off = req.addr - DTCM_BASE;
	assign itcm_idx = itcm_off[ITCM_AW+1:2];
	assign dtcm_idx = dtcm_off[DTCM_AW+1:2];

	// Once per held sel, the ready cycle blocks a repeat
	assign access = req.sel && !ready_q;

	always_ff @(posedge sys_root_clk or negedge rst_n) begin
		if (!rst_n)
			ready_q <= 1'b0;
		else
			ready_q <= access;
	end

	// Arrays and read register
	always_ff @(posedge sys_root_clk) begin
		if (access && req.write) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (req.strb[b]) begin
					if (target == ITCM)
						itcm_mem[itcm_idx][8*b +: 8] <= req.wdata[8*b +: 8];
					else
						dtcm_mem[dtcm_idx][8*b +: 8] <= req.wdata[8*b +: 8];
				end
			end
		end
		if (access)
			rdata_q <= (target == ITCM) ? itcm_mem[itcm_idx] : dtcm_mem[dtcm_idx];
	end

	assign rsp = '{ready: ready_q, err: 1'b0, rdata: rdata_q};	// TCM never faults

endmodule

// ==== src/ahb_matrix.sv ====
// Shared bus interconnect

`timescale 1ns/1ps

module ahb_matrix (
	input  logic sys_root_clk,
	input  logic rst_n,
	input  fp_pkg::ahb_req_t mst_req [fp_pkg::NUM_MASTERS],
	output fp_pkg::ahb_rsp_t mst_rsp [fp_pkg::NUM_MASTERS],
	output fp_pkg::ahb_req_t tcm_req,
	output fp_pkg::target_e  tcm_target,
	input  fp_pkg::ahb_rsp_t tcm_rsp,
	output fp_pkg::ahb_req_t apb_br_req,
	input  fp_pkg::ahb_rsp_t apb_br_rsp
);

	import fp_pkg::*;

	logic [NUM_MASTERS-1:0] grant;
	logic done;
	logic busy_q;				// Latched transfer in flight
	ahb_req_t gnt_req;
	ahb_req_t cur_req_q;
	target_e cur_tgt_q;
	ahb_rsp_t sel_rsp;

	// Address decode, unsigned wrap keeps the range check to one compare
	function automatic target_e decode(input logic [ADDR_W-1:0] addr);
		target_e t;

		if ((addr - ITCM_BASE) < ITCM_BYTES)
			t = ITCM;
		else if ((addr - DTCM_BASE) < DTCM_BYTES)
			t = DTCM;
		else if ((addr & APB_REGION_MASK) == APB_BASE)
			t = APB;
		else
			t = NONE;
		return t;
	endfunction

	bus_arbiter u_bus_arbiter (
		.sys_root_clk	(sys_root_clk),
		.rst_n			(rst_n),
		.req			({mst_req[2].sel, mst_req[1].sel, mst_req[0].sel}),
		.done			(done),
		.grant			(grant)
	);

	// ======================================================================
	// Request capture
	// ======================================================================
	always_comb begin
		gnt_req = '0;
		for (int m = 0; m < NUM_MASTERS; m++)
			if (grant[m])
				gnt_req = mst_req[m];
	end

	always_ff @(posedge sys_root_clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			cur_tgt_q <= NONE;
		end else if (busy_q) begin
			if (done)
				busy_q <= 1'b0;
		end else if (|grant) begin
			busy_q <= 1'b1;
			cur_tgt_q <= decode(gnt_req.addr);	// Decoded once per transfer
		end
	end

	always_ff @(posedge sys_root_clk) begin
		if (!busy_q && |grant)
			cur_req_q <= gnt_req;
	end

	// ======================================================================
	// Slave requests and response return
	// ======================================================================
	always_comb begin
		tcm_req = cur_req_q;
		tcm_req.sel = busy_q && (cur_tgt_q == ITCM || cur_tgt_q == DTCM);
		apb_br_req = cur_req_q;
		apb_br_req.sel = busy_q && cur_tgt_q == APB;
	end

	assign tcm_target = cur_tgt_q;

	always_comb begin
		case (cur_tgt_q)
			ITCM, DTCM: sel_rsp = tcm_rsp;
			APB:        sel_rsp = apb_br_rsp;
			default:    sel_rsp = '{ready: 1'b1, err: 1'b1, rdata: '0};	// Unmapped
		endcase
	end

	assign done = busy_q && sel_rsp.ready;

	// Only the owner sees the response
	always_comb begin
		for (int m = 0; m < NUM_MASTERS; m++)
			mst_rsp[m] = (busy_q && grant[m]) ? sel_rsp : '0;
	end

endmodule

// ==== src/bus_arbiter.sv ====
// Round-robin bus arbiter

`timescale 1ns/1ps

module bus_arbiter (
	input  logic sys_root_clk,
	input  logic rst_n,
	input  logic [fp_pkg::NUM_MASTERS-1:0] req,		// Held sel of each master
	input  logic done,								// Transfer finished
	output logic [fp_pkg::NUM_MASTERS-1:0] grant	// One-hot, held until done
);

	import fp_pkg::*;

	logic [MST_IDX_W-1:0] last_q;		// Master served last
	logic [MST_IDX_W-1:0] next_idx;
	logic [NUM_MASTERS-1:0] next_grant;

	// ======================================================================
	// Next winner, searching from the master after last_q
	// ======================================================================
	always_comb begin
		int idx;

		next_grant = '0;
		next_idx = last_q;
		// Walk backwards so the closest requester wins
		for (int k = NUM_MASTERS; k >= 1; k--) begin
			idx = (int'(last_q) + k) % NUM_MASTERS;
			if (req[idx]) begin
				next_grant = '0;
				next_grant[idx] = 1'b1;
				next_idx = MST_IDX_W'(idx);
			end
		end
	end

	// Grant register
	always_ff @(posedge sys_root_clk or negedge rst_n) begin
		if (!rst_n) begin
			grant <= '0;
			last_q <= MST_IDX_W'(NUM_MASTERS - 1);	// Master 0 goes first
		end else if (|grant) begin
			if (done)
				grant <= '0;		// Bus idle for one cycle, stale sel drops
		end else if (|req) begin
			grant <= next_grant;
			last_q <= next_idx;
		end
	end

endmodule

// ==== src/fp_pkg.sv ====
// Full power domain definitions

package fp_pkg;

	// ======================================================================
	// Bus widths and masters
	// ======================================================================
	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;
	localparam int STRB_W = DATA_W / 8;		// One strobe per byte lane

	localparam int NUM_MASTERS = 3;			// 0 instr, 1 data, 2 system
	localparam int MST_IDX_W = $clog2(NUM_MASTERS);

	// ======================================================================
	// Memory map
	// ======================================================================
	localparam logic [ADDR_W-1:0] ITCM_BASE = 32'h0000_0000;
	localparam logic [ADDR_W-1:0] DTCM_BASE = 32'h0001_0000;
	localparam logic [ADDR_W-1:0] APB_BASE = 32'h4000_0000;
	localparam logic [ADDR_W-1:0] APB_REGION_MASK = 32'hFFFF_0000;	// 64 KB window

	localparam int ITCM_WORDS = 256;
	localparam int DTCM_WORDS = 64;
	localparam int NUM_APB_REGS = 16;

	// Derived region sizes and index widths
	localparam logic [ADDR_W-1:0] ITCM_BYTES = ADDR_W'(ITCM_WORDS * STRB_W);
	localparam logic [ADDR_W-1:0] DTCM_BYTES = ADDR_W'(DTCM_WORDS * STRB_W);
	localparam int ITCM_AW = $clog2(ITCM_WORDS);
	localparam int DTCM_AW = $clog2(DTCM_WORDS);
	localparam int APB_REG_AW = $clog2(NUM_APB_REGS);

	// ======================================================================
	// Bus payloads
	// ======================================================================
	typedef struct packed {
		logic sel;					// Held until ready
		logic write;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] strb;
	} ahb_req_t;

	typedef struct packed {
		logic ready;				// One cycle pulse
		logic err;
		logic [DATA_W-1:0] rdata;
	} ahb_rsp_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [ADDR_W-1:0] paddr;	// Offset inside the window
		logic [DATA_W-1:0] pwdata;
		logic [STRB_W-1:0] pstrb;
	} apb_req_t;

	typedef struct packed {
		logic pready;
		logic pslverr;
		logic [DATA_W-1:0] prdata;
	} apb_rsp_t;

	// Decoded slave
	typedef enum logic [1:0] {ITCM, DTCM, APB, NONE} target_e;

endpackage
